// File: common/pcie_dll_pkg.sv
/*
 * pcie dll receive package
 * word widths, DLLP type codes, flow-control class and phase
 * encodings and buffer sizing for the VC0 DLLP receive path
 */
`default_nettype none

package pcie_dll_pkg;

  // one word from the physical layer, either a DLLP body or its CRC word
  typedef logic [31:0] dll_word_t;

  typedef logic [15:0] crc16_t;

  // ack/nak sequence number
  typedef logic [11:0] seq_num_t;

  // advertised credits
  typedef logic [7:0]  fc_hdr_t;
  typedef logic [11:0] fc_data_t;

  // type byte, body bits 31:24
  typedef logic [7:0]  dllp_type_t;

  // ack/nak
  localparam dllp_type_t TYPE_ACK         = 8'h00;
  localparam dllp_type_t TYPE_NAK         = 8'h10;

  // flow-control init, first round
  localparam dllp_type_t TYPE_INITFC1_P   = 8'h40;
  localparam dllp_type_t TYPE_INITFC1_NP  = 8'h50;
  localparam dllp_type_t TYPE_INITFC1_CPL = 8'h60;

  // flow-control init, second round
  localparam dllp_type_t TYPE_INITFC2_P   = 8'hC0;
  localparam dllp_type_t TYPE_INITFC2_NP  = 8'hD0;
  localparam dllp_type_t TYPE_INITFC2_CPL = 8'hE0;

  // credit updates once the link is active
  localparam dllp_type_t TYPE_UPDATEFC_P   = 8'h80;
  localparam dllp_type_t TYPE_UPDATEFC_NP  = 8'h90;
  localparam dllp_type_t TYPE_UPDATEFC_CPL = 8'hA0;

  // traffic class, matches type bits 5:4 of every fc DLLP
  typedef enum logic [1:0] {
    FC_P   = 2'd0,
    FC_NP  = 2'd1,
    FC_CPL = 2'd2
  } fc_class_e;

  typedef enum logic [1:0] {
    PH_INIT1,
    PH_INIT2,
    PH_UPDATE
  } fc_phase_e;

  localparam int NUM_FC_CLASSES = 3;

  // buffer entries, also the credits the sender starts with
  localparam int RX_BUF_DEPTH = 4;
  localparam int RX_BUF_AW    = $clog2(RX_BUF_DEPTH);

  // DLLP crc-16
  localparam crc16_t CRC_POLY = 16'h100B;
  localparam crc16_t CRC_SEED = 16'hFFFF;

endpackage

`default_nettype wire

// File: hw/dllp_rx/dllp_rx_buffer.sv
/*
 * dllp receive buffer
 * small circular FIFO fed by the physical layer under credit control,
 * one credit goes back for each word the decoder pops
 */
`timescale 1ns/1ps
`default_nettype none

module dllp_rx_buffer (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire pcie_dll_pkg::dll_word_t wr_word_i,
  input  wire logic                    wr_last_i,
  input  wire logic                    wr_valid_i,
  input  wire logic                    pop_i,
  output pcie_dll_pkg::dll_word_t      rd_word_o,
  output logic                         rd_last_o,
  output logic                         rd_valid_o,
  output logic                         credit_o
);

  pcie_dll_pkg::dll_word_t mem_word [pcie_dll_pkg::RX_BUF_DEPTH];
  logic                    mem_last [pcie_dll_pkg::RX_BUF_DEPTH];

  logic [pcie_dll_pkg::RX_BUF_AW-1:0] wr_ptr_r;
  logic [pcie_dll_pkg::RX_BUF_AW-1:0] rd_ptr_r;
  logic [pcie_dll_pkg::RX_BUF_AW:0]   count_r;
  logic                               pop_ok;

  assign rd_valid_o = (count_r != '0);
  assign pop_ok     = pop_i && rd_valid_o;
  assign rd_word_o  = mem_word[rd_ptr_r];
  assign rd_last_o  = mem_last[rd_ptr_r];

  // sender never writes without a credit, so no full check here
  always_ff @(posedge clk_i) begin
    if (wr_valid_i) begin
      mem_word[wr_ptr_r] <= wr_word_i;
      mem_last[wr_ptr_r] <= wr_last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (wr_valid_i) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
      case ({wr_valid_i, pop_ok})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      // freed entry goes back to the sender
      credit_o <= pop_ok;
    end
  end

endmodule

`default_nettype wire

// File: hw/dllp_rx/dllp_crc16.sv
/*
 * dllp crc-16
 * combinational CRC over one 32-bit DLLP body, bytes taken msb first
 * and each byte lsb first, result complemented and bit reversed
 */
`timescale 1ns/1ps
`default_nettype none

module dllp_crc16 (
  input  wire pcie_dll_pkg::dll_word_t body_i,
  output pcie_dll_pkg::crc16_t         crc_o
);

  always_comb begin : crc_calc
    pcie_dll_pkg::crc16_t lfsr;
    logic                 fb;

    lfsr = pcie_dll_pkg::CRC_SEED;
    fb   = 1'b0;

    // serial lfsr unrolled over the 32 body bits
    for (int i = 0; i < 32; i++) begin
      fb   = lfsr[15] ^ body_i[(3 - i / 8) * 8 + (i % 8)];
      lfsr = {lfsr[14:0], 1'b0};
      if (fb) begin
        lfsr = lfsr ^ pcie_dll_pkg::CRC_POLY;
      end
    end

    lfsr = ~lfsr;

    // sent on the wire in reversed bit order
    for (int j = 0; j < 16; j++) begin
      crc_o[j] = lfsr[15 - j];
    end
  end

endmodule

`default_nettype wire

// File: hw/dllp_rx/dllp_decoder.sv
/*
 * dllp decoder
 * pairs each DLLP body with its CRC word, checks the CRC and hands
 * ack/nak reports or flow-control loads on one cycle later
 */
`timescale 1ns/1ps
`default_nettype none

module dllp_decoder (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    link_up_i,
  input  wire pcie_dll_pkg::dll_word_t word_i,
  input  wire logic                    last_i,
  input  wire logic                    valid_i,
  input  wire pcie_dll_pkg::crc16_t    crc_i,
  output logic                         pop_o,
  output pcie_dll_pkg::dll_word_t      body_o,
  output pcie_dll_pkg::seq_num_t       seq_num_o,
  output logic                         seq_vld_o,
  output logic                         seq_ack_o,
  output logic                         crc_err_o,
  output logic                         fc_load_o,
  output pcie_dll_pkg::fc_class_e      fc_class_o,
  output pcie_dll_pkg::fc_phase_e      fc_phase_o,
  output pcie_dll_pkg::fc_hdr_t        fc_hdr_o,
  output pcie_dll_pkg::fc_data_t       fc_data_o
);

  typedef enum logic [1:0] {
    ST_BODY,
    ST_CRC,
    ST_DISPATCH
  } dec_state_e;

  dec_state_e                 state_r;
  pcie_dll_pkg::dll_word_t    body_r;
  pcie_dll_pkg::dllp_type_t   type_w;
  logic                       crc_ok_r;

  // nothing leaves the buffer while the link is down
  assign pop_o = link_up_i && valid_i && (state_r != ST_DISPATCH);

  assign body_o    = body_r;
  assign type_w    = body_r[31:24];
  assign seq_num_o = body_r[11:0];
  assign fc_hdr_o  = body_r[21:14];
  assign fc_data_o = body_r[11:0];

  // a later body word without last simply replaces the pending one
  always_ff @(posedge clk_i) begin
    if (pop_o && !last_i) begin
      body_r <= word_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r   <= ST_BODY;
      crc_ok_r  <= 1'b0;
      crc_err_o <= 1'b0;
    end else begin
      crc_err_o <= 1'b0;
      case (state_r)
        ST_BODY: begin
          if (pop_o) begin
            if (last_i) begin
              // crc word with no body in front of it
              crc_err_o <= 1'b1;
            end else begin
              state_r <= ST_CRC;
            end
          end
        end
        ST_CRC: begin
          if (pop_o && last_i) begin
            crc_ok_r  <= (word_i[15:0] == crc_i);
            crc_err_o <= (word_i[15:0] != crc_i);
            state_r   <= ST_DISPATCH;
          end
        end
        default: state_r <= ST_BODY;
      endcase
    end
  end

  always_comb begin
    seq_vld_o  = 1'b0;
    seq_ack_o  = 1'b0;
    fc_load_o  = 1'b0;
    fc_phase_o = pcie_dll_pkg::PH_UPDATE;
    // class sits in type bits 5:4 of every fc DLLP
    fc_class_o = pcie_dll_pkg::fc_class_e'(type_w[5:4]);
    if (state_r == ST_DISPATCH && crc_ok_r) begin
      case (type_w)
        pcie_dll_pkg::TYPE_ACK, pcie_dll_pkg::TYPE_NAK: begin
          seq_vld_o = 1'b1;
          seq_ack_o = (type_w == pcie_dll_pkg::TYPE_ACK);
        end
        pcie_dll_pkg::TYPE_INITFC1_P, pcie_dll_pkg::TYPE_INITFC1_NP,
        pcie_dll_pkg::TYPE_INITFC1_CPL: begin
          fc_load_o  = 1'b1;
          fc_phase_o = pcie_dll_pkg::PH_INIT1;
        end
        pcie_dll_pkg::TYPE_INITFC2_P, pcie_dll_pkg::TYPE_INITFC2_NP,
        pcie_dll_pkg::TYPE_INITFC2_CPL: begin
          fc_load_o  = 1'b1;
          fc_phase_o = pcie_dll_pkg::PH_INIT2;
        end
        pcie_dll_pkg::TYPE_UPDATEFC_P, pcie_dll_pkg::TYPE_UPDATEFC_NP,
        pcie_dll_pkg::TYPE_UPDATEFC_CPL: begin
          fc_load_o = 1'b1;
        end
        // pm and vendor DLLPs end up here
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/fc_credit_store.sv
/*
 * flow-control credit store
 * header and data credits of one traffic class plus the sticky
 * InitFC1/InitFC2 flags
 */
`timescale 1ns/1ps
`default_nettype none

module fc_credit_store #(
  parameter pcie_dll_pkg::fc_class_e CLASS_ID = pcie_dll_pkg::FC_P
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    clear_i,
  input  wire logic                    load_i,
  input  wire pcie_dll_pkg::fc_class_e class_i,
  input  wire pcie_dll_pkg::fc_phase_e phase_i,
  input  wire pcie_dll_pkg::fc_hdr_t   hdr_i,
  input  wire pcie_dll_pkg::fc_data_t  data_i,
  output pcie_dll_pkg::fc_hdr_t        hdr_o,
  output pcie_dll_pkg::fc_data_t       data_o,
  output logic                         stored1_o,
  output logic                         stored2_o,
  output logic                         loaded_o
);

  logic hit;

  assign hit = load_i && (class_i == CLASS_ID);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      hdr_o     <= '0;
      data_o    <= '0;
      stored1_o <= 1'b0;
      stored2_o <= 1'b0;
      loaded_o  <= 1'b0;
    end else begin
      // InitFC2 counts as an update too once the link is active
      loaded_o <= hit && (phase_i != pcie_dll_pkg::PH_INIT1);
      if (hit) begin
        hdr_o  <= hdr_i;
        data_o <= data_i;
      end
      // link drop clears flags, credits stay
      if (clear_i) begin
        stored1_o <= 1'b0;
        stored2_o <= 1'b0;
      end else if (hit) begin
        if (phase_i == pcie_dll_pkg::PH_INIT1) begin
          stored1_o <= 1'b1;
        end
        if (phase_i == pcie_dll_pkg::PH_INIT2) begin
          stored2_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fc_init_tracker.sv
/*
 * flow-control init tracker
 * steps InitFC1 -> InitFC2 -> active from the store flags and tells
 * the transmit side when updated credits may be used
 */
`timescale 1ns/1ps
`default_nettype none

module fc_init_tracker (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_i,
  input  wire logic                                    link_up_i,
  input  wire logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] stored1_i,
  input  wire logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] stored2_i,
  input  wire logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] loaded_i,
  output logic                                         fc1_done_o,
  output logic                                         fc2_done_o,
  output logic                                         update_fc_o,
  output logic                                         clear_o
);

  typedef enum logic [1:0] {
    FI_INIT1,
    FI_INIT2,
    FI_ACTIVE
  } fi_state_e;

  fi_state_e state_r;
  logic      link_r;

  assign fc1_done_o = (state_r != FI_INIT1);
  assign fc2_done_o = (state_r == FI_ACTIVE);

  // first low cycle of the link wipes the store flags
  assign clear_o = link_r && !link_up_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r     <= FI_INIT1;
      link_r      <= 1'b0;
      update_fc_o <= 1'b0;
    end else begin
      link_r      <= link_up_i;
      update_fc_o <= 1'b0;
      if (!link_up_i) begin
        state_r <= FI_INIT1;
      end else begin
        case (state_r)
          FI_INIT1: begin
            if (&stored1_i) begin
              state_r <= FI_INIT2;
            end
          end
          FI_INIT2: begin
            if (&stored2_i) begin
              state_r     <= FI_ACTIVE;
              update_fc_o <= 1'b1;
            end
          end
          FI_ACTIVE: update_fc_o <= |loaded_i;
          default:   state_r <= FI_INIT1;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dll_rx_top.sv
/*
 * dll receive top
 * VC0 DLLP receive path from buffer through CRC check and decode to
 * the per-class credit stores and the init tracker
 */
`timescale 1ns/1ps
`default_nettype none

module dll_rx_top (
  input  wire logic                    clk_i,
  input  wire logic                    rst_i,
  input  wire logic                    link_up_i,
  input  wire pcie_dll_pkg::dll_word_t rx_word_i,
  input  wire logic                    rx_last_i,
  input  wire logic                    rx_valid_i,
  output logic                         rx_credit_o,
  output pcie_dll_pkg::seq_num_t       seq_num_o,
  output logic                         seq_vld_o,
  output logic                         seq_ack_o,
  output logic                         crc_err_o,
  output pcie_dll_pkg::fc_hdr_t        fc_ph_o,
  output pcie_dll_pkg::fc_data_t       fc_pd_o,
  output pcie_dll_pkg::fc_hdr_t        fc_nph_o,
  output pcie_dll_pkg::fc_data_t       fc_npd_o,
  output pcie_dll_pkg::fc_hdr_t        fc_cplh_o,
  output pcie_dll_pkg::fc_data_t       fc_cpld_o,
  output logic                         fc1_done_o,
  output logic                         fc2_done_o,
  output logic                         update_fc_o
);

  pcie_dll_pkg::dll_word_t  buf_word;
  logic                     buf_last;
  logic                     buf_valid;
  logic                     pop;
  pcie_dll_pkg::dll_word_t  body;
  pcie_dll_pkg::crc16_t     crc_exp;
  logic                     fc_load;
  pcie_dll_pkg::fc_class_e  fc_class;
  pcie_dll_pkg::fc_phase_e  fc_phase;
  pcie_dll_pkg::fc_hdr_t    fc_hdr;
  pcie_dll_pkg::fc_data_t   fc_data;
  logic                     fc_clear;

  // per-class store outputs
  pcie_dll_pkg::fc_hdr_t                 hdr_w  [pcie_dll_pkg::NUM_FC_CLASSES];
  pcie_dll_pkg::fc_data_t                data_w [pcie_dll_pkg::NUM_FC_CLASSES];
  logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] stored1_w;
  logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] stored2_w;
  logic [pcie_dll_pkg::NUM_FC_CLASSES-1:0] loaded_w;

  dllp_rx_buffer dllp_rx_buffer_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_word_i (rx_word_i),
    .wr_last_i (rx_last_i),
    .wr_valid_i(rx_valid_i),
    .pop_i     (pop),
    .rd_word_o (buf_word),
    .rd_last_o (buf_last),
    .rd_valid_o(buf_valid),
    .credit_o  (rx_credit_o)
  );

  dllp_crc16 dllp_crc16_i (
    .body_i(body),
    .crc_o (crc_exp)
  );

  dllp_decoder dllp_decoder_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .link_up_i (link_up_i),
    .word_i    (buf_word),
    .last_i    (buf_last),
    .valid_i   (buf_valid),
    .crc_i     (crc_exp),
    .pop_o     (pop),
    .body_o    (body),
    .seq_num_o (seq_num_o),
    .seq_vld_o (seq_vld_o),
    .seq_ack_o (seq_ack_o),
    .crc_err_o (crc_err_o),
    .fc_load_o (fc_load),
    .fc_class_o(fc_class),
    .fc_phase_o(fc_phase),
    .fc_hdr_o  (fc_hdr),
    .fc_data_o (fc_data)
  );

  for (genvar k = 0; k < pcie_dll_pkg::NUM_FC_CLASSES; k++) begin : g_store
    fc_credit_store #(
      .CLASS_ID(pcie_dll_pkg::fc_class_e'(k))
    ) fc_credit_store_i (
      .clk_i    (clk_i),
      .rst_i    (rst_i),
      .clear_i  (fc_clear),
      .load_i   (fc_load),
      .class_i  (fc_class),
      .phase_i  (fc_phase),
      .hdr_i    (fc_hdr),
      .data_i   (fc_data),
      .hdr_o    (hdr_w[k]),
      .data_o   (data_w[k]),
      .stored1_o(stored1_w[k]),
      .stored2_o(stored2_w[k]),
      .loaded_o (loaded_w[k])
    );
  end

  fc_init_tracker fc_init_tracker_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .link_up_i  (link_up_i),
    .stored1_i  (stored1_w),
    .stored2_i  (stored2_w),
    .loaded_i   (loaded_w),
    .fc1_done_o (fc1_done_o),
    .fc2_done_o (fc2_done_o),
    .update_fc_o(update_fc_o),
    .clear_o    (fc_clear)
  );

  assign fc_ph_o   = hdr_w[pcie_dll_pkg::FC_P];
  assign fc_pd_o   = data_w[pcie_dll_pkg::FC_P];
  assign fc_nph_o  = hdr_w[pcie_dll_pkg::FC_NP];
  assign fc_npd_o  = data_w[pcie_dll_pkg::FC_NP];
  assign fc_cplh_o = hdr_w[pcie_dll_pkg::FC_CPL];
  assign fc_cpld_o = data_w[pcie_dll_pkg::FC_CPL];

endmodule

`default_nettype wire

// File: sim/tb_clk_gen.sv
/*
 * testbench clock generator
 * free-running clock, starts low
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// File: sim/dll_rx_tb.sv
/*
 * dll receive testbench
 * directed tests for ack/nak reports, crc errors, flow-control init
 * and updates, and credit back-pressure across a link drop
 */
`timescale 1ns/1ps
`default_nettype none

module dll_rx_tb;

  localparam int CLK_NS        = 20;
  localparam int RESET_CYC     = 10;
  localparam int LINK_DOWN_CYC = 40;
  localparam int DRAIN_LIMIT   = 200;
  // dllps over all tests: 8 + 2 + 6 + 1 + 20 + 2
  localparam int NUM_DLLPS     = 39;
  localparam int CYC_PER_DLLP  = 12;
  localparam int TEST_CYC      = RESET_CYC + NUM_DLLPS * CYC_PER_DLLP + LINK_DOWN_CYC + 6 * 16;
  localparam int WATCHDOG_NS   = TEST_CYC * CLK_NS + 2000;

  logic                    clk_i;
  logic                    rst_i;
  logic                    link_up_i;
  pcie_dll_pkg::dll_word_t rx_word_i;
  logic                    rx_last_i;
  logic                    rx_valid_i;
  logic                    rx_credit_o;
  pcie_dll_pkg::seq_num_t  seq_num_o;
  logic                    seq_vld_o;
  logic                    seq_ack_o;
  logic                    crc_err_o;
  pcie_dll_pkg::fc_hdr_t   fc_ph_o;
  pcie_dll_pkg::fc_data_t  fc_pd_o;
  pcie_dll_pkg::fc_hdr_t   fc_nph_o;
  pcie_dll_pkg::fc_data_t  fc_npd_o;
  pcie_dll_pkg::fc_hdr_t   fc_cplh_o;
  pcie_dll_pkg::fc_data_t  fc_cpld_o;
  logic                    fc1_done_o;
  logic                    fc2_done_o;
  logic                    update_fc_o;

  int checks          = 0;
  int errors          = 0;
  int credit_errors   = 0;
  int words_sent      = 0;
  int credit_pulses   = 0;
  int crc_err_cnt     = 0;
  int update_cnt      = 0;
  int reports_checked = 0;
  logic [31:0] rnd_state = 32'hfcfe_10cb;

  // reports seen on the DUT and the ones expected, in order
  pcie_dll_pkg::seq_num_t seq_num_q [$];
  logic                   seq_ack_q [$];
  pcie_dll_pkg::seq_num_t exp_num_q [$];
  logic                   exp_ack_q [$];
  pcie_dll_pkg::fc_hdr_t  exp_hdr  [pcie_dll_pkg::NUM_FC_CLASSES];
  pcie_dll_pkg::fc_data_t exp_data [pcie_dll_pkg::NUM_FC_CLASSES];

  tb_clk_gen #(.PERIOD_NS(CLK_NS)) tb_clk_gen_i (.clk_o(clk_i));

  dll_rx_top dll_rx_top_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .link_up_i  (link_up_i),
    .rx_word_i  (rx_word_i),
    .rx_last_i  (rx_last_i),
    .rx_valid_i (rx_valid_i),
    .rx_credit_o(rx_credit_o),
    .seq_num_o  (seq_num_o),
    .seq_vld_o  (seq_vld_o),
    .seq_ack_o  (seq_ack_o),
    .crc_err_o  (crc_err_o),
    .fc_ph_o    (fc_ph_o),
    .fc_pd_o    (fc_pd_o),
    .fc_nph_o   (fc_nph_o),
    .fc_npd_o   (fc_npd_o),
    .fc_cplh_o  (fc_cplh_o),
    .fc_cpld_o  (fc_cpld_o),
    .fc1_done_o (fc1_done_o),
    .fc2_done_o (fc2_done_o),
    .update_fc_o(update_fc_o)
  );

  // output monitor, sampled on the rising edge
  always @(posedge clk_i) begin
    if (!rst_i) begin
      if (rx_credit_o) begin
        credit_pulses = credit_pulses + 1;
        if (credit_pulses > words_sent) begin
          credit_errors = credit_errors + 1;
          $display("credit returned with no word outstanding at %0t", $time);
        end
      end
      if (seq_vld_o) begin
        seq_num_q.push_back(seq_num_o);
        seq_ack_q.push_back(seq_ack_o);
      end
      if (crc_err_o) begin
        crc_err_cnt = crc_err_cnt + 1;
      end
      if (update_fc_o) begin
        update_cnt = update_cnt + 1;
      end
    end
  end

  function automatic logic [31:0] next_random();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // bytes msb first, bits of each byte lsb first, then complement and reverse
  function automatic pcie_dll_pkg::crc16_t ref_crc(input pcie_dll_pkg::dll_word_t body);
    pcie_dll_pkg::crc16_t c;
    pcie_dll_pkg::crc16_t res;
    logic [7:0]           b;
    logic                 in_bit;
    c = pcie_dll_pkg::CRC_SEED;
    for (int n = 3; n >= 0; n--) begin
      b = body[n * 8 +: 8];
      for (int k = 0; k < 8; k++) begin
        in_bit = b[k] ^ c[15];
        c = c << 1;
        if (in_bit) begin
          c = c ^ pcie_dll_pkg::CRC_POLY;
        end
      end
    end
    c = ~c;
    for (int k = 0; k < 16; k++) begin
      res[k] = c[15 - k];
    end
    return res;
  endfunction

  function automatic pcie_dll_pkg::dll_word_t ack_body(input logic ack,
                                                       input pcie_dll_pkg::seq_num_t num);
    return {ack ? pcie_dll_pkg::TYPE_ACK : pcie_dll_pkg::TYPE_NAK, 12'h000, num};
  endfunction

  function automatic pcie_dll_pkg::dll_word_t fc_body(input pcie_dll_pkg::dllp_type_t t,
                                                      input pcie_dll_pkg::fc_hdr_t hdr,
                                                      input pcie_dll_pkg::fc_data_t data);
    return {t, 2'b00, hdr, 2'b00, data};
  endfunction

  function automatic pcie_dll_pkg::dllp_type_t init_type(input int round, input int cls);
    case (cls)
      0:       return (round == 1) ? pcie_dll_pkg::TYPE_INITFC1_P : pcie_dll_pkg::TYPE_INITFC2_P;
      1:       return (round == 1) ? pcie_dll_pkg::TYPE_INITFC1_NP : pcie_dll_pkg::TYPE_INITFC2_NP;
      default: return (round == 1) ? pcie_dll_pkg::TYPE_INITFC1_CPL
                                   : pcie_dll_pkg::TYPE_INITFC2_CPL;
    endcase
  endfunction

  task automatic check_seq(input string name, input pcie_dll_pkg::seq_num_t exp_num,
                           input logic exp_ack, input pcie_dll_pkg::seq_num_t act_num,
                           input logic act_ack);
    checks++;
    if (act_num !== exp_num || act_ack !== exp_ack) begin
      errors++;
      $display("mismatch %s: expected seq %h ack %b, actual seq %h ack %b",
               name, exp_num, exp_ack, act_num, act_ack);
    end
  endtask

  task automatic check_credits(input string name, input int cls,
                               input pcie_dll_pkg::fc_hdr_t exp_h,
                               input pcie_dll_pkg::fc_data_t exp_d);
    pcie_dll_pkg::fc_hdr_t  act_h;
    pcie_dll_pkg::fc_data_t act_d;
    case (cls)
      0: begin
        act_h = fc_ph_o;
        act_d = fc_pd_o;
      end
      1: begin
        act_h = fc_nph_o;
        act_d = fc_npd_o;
      end
      default: begin
        act_h = fc_cplh_o;
        act_d = fc_cpld_o;
      end
    endcase
    checks++;
    if (act_h !== exp_h || act_d !== exp_d) begin
      errors++;
      $display("mismatch %s class %0d: expected hdr %h data %h, actual hdr %h data %h",
               name, cls, exp_h, exp_d, act_h, act_d);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_all_credits(input string name);
    check_credits(name, 0, exp_hdr[0], exp_data[0]);
    check_credits(name, 1, exp_hdr[1], exp_data[1]);
    check_credits(name, 2, exp_hdr[2], exp_data[2]);
  endtask

  task automatic check_reports(input string name);
    check_count({name, " report count"}, exp_num_q.size(), seq_num_q.size());
    while (reports_checked < exp_num_q.size() && reports_checked < seq_num_q.size()) begin
      check_seq(name, exp_num_q[reports_checked], exp_ack_q[reports_checked],
                seq_num_q[reports_checked], seq_ack_q[reports_checked]);
      reports_checked++;
    end
  endtask

  // sender model, one word per credit held
  task automatic send_word(input pcie_dll_pkg::dll_word_t word, input logic last, input int gap);
    repeat (gap) @(negedge clk_i);
    while (words_sent - credit_pulses >= pcie_dll_pkg::RX_BUF_DEPTH) begin
      @(negedge clk_i);
    end
    rx_word_i  = word;
    rx_last_i  = last;
    rx_valid_i = 1'b1;
    words_sent = words_sent + 1;
    @(negedge clk_i);
    rx_valid_i = 1'b0;
  endtask

  task automatic send_dllp(input pcie_dll_pkg::dll_word_t body,
                           input pcie_dll_pkg::crc16_t flip, input logic spaced);
    logic [31:0] r;
    r = next_random();
    send_word(body, 1'b0, spaced ? int'(r[25:24]) : 0);
    // upper half of the crc word is don't care
    send_word({r[15:0], ref_crc(body) ^ flip}, 1'b1, spaced ? int'(r[29:28]) : 0);
  endtask

  task automatic send_ack(input logic ack, input pcie_dll_pkg::seq_num_t num, input logic spaced);
    exp_num_q.push_back(num);
    exp_ack_q.push_back(ack);
    send_dllp(ack_body(ack, num), 16'h0000, spaced);
  endtask

  task automatic send_fc(input pcie_dll_pkg::dllp_type_t t, input int cls,
                         input pcie_dll_pkg::fc_hdr_t hdr, input pcie_dll_pkg::fc_data_t data);
    exp_hdr[cls]  = hdr;
    exp_data[cls] = data;
    send_dllp(fc_body(t, hdr, data), 16'h0000, 1'b1);
  endtask

  // all credits back, then room for dispatch, store and tracker stages
  task automatic wait_drain(input string name);
    int cyc;
    cyc = 0;
    while (words_sent != credit_pulses && cyc < DRAIN_LIMIT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (words_sent != credit_pulses) begin
      errors++;
      $display("%s: buffer still holds %0d words after %0d cycles",
               name, words_sent - credit_pulses, DRAIN_LIMIT);
    end
    repeat (4) @(negedge clk_i);
  endtask

  task automatic ack_nak_reports();
    logic [31:0] r;
    for (int i = 0; i < 8; i++) begin
      r = next_random();
      send_ack(r[8], r[27:16], 1'b1);
    end
    wait_drain("ack_nak");
    check_reports("ack_nak");
  endtask

  task automatic corrupted_crc();
    int err0;
    err0 = crc_err_cnt;
    send_dllp(ack_body(1'b1, 12'h5a5), 16'h0100, 1'b0);
    // a bad fc DLLP must leave the stores alone
    send_dllp(fc_body(pcie_dll_pkg::TYPE_INITFC1_P, 8'h21, 12'h345), 16'h8000, 1'b0);
    wait_drain("bad_crc");
    check_count("bad_crc crc_err pulses", err0 + 2, crc_err_cnt);
    check_reports("bad_crc");
    check_all_credits("bad_crc");
  endtask

  task automatic fc_initialization();
    logic [31:0] r;
    int          upd0;
    upd0 = update_cnt;
    for (int c = 0; c < 3; c++) begin
      r = next_random();
      send_fc(init_type(1, c), c, r[7:0], r[27:16]);
    end
    wait_drain("fc_init1");
    check_flag("fc_init1 fc1_done", 1'b1, fc1_done_o);
    check_flag("fc_init1 fc2_done", 1'b0, fc2_done_o);
    check_count("fc_init1 update pulses", upd0, update_cnt);
    for (int c = 0; c < 3; c++) begin
      r = next_random();
      send_fc(init_type(2, c), c, r[23:16], r[11:0]);
    end
    wait_drain("fc_init2");
    check_flag("fc_init2 fc2_done", 1'b1, fc2_done_o);
    check_count("fc_init2 update pulses", upd0 + 1, update_cnt);
    check_all_credits("fc_init2");
  endtask

  task automatic np_credit_update();
    logic [31:0] r;
    int          upd0;
    upd0 = update_cnt;
    r = next_random();
    send_fc(pcie_dll_pkg::TYPE_UPDATEFC_NP, 1, r[31:24], r[19:8]);
    wait_drain("update_np");
    check_count("update_np update pulses", upd0 + 1, update_cnt);
    check_all_credits("update_np");
  endtask

  task automatic link_drop_backpressure();
    logic [31:0] r;
    int          pulses0;
    int          seq0;
    link_up_i = 1'b0;
    @(negedge clk_i);
    check_flag("link_drop fc1_done", 1'b0, fc1_done_o);
    check_flag("link_drop fc2_done", 1'b0, fc2_done_o);
    pulses0 = credit_pulses;
    seq0    = seq_num_q.size();
    fork
      begin
        for (int i = 0; i < 20; i++) begin
          r = next_random();
          send_ack(r[4], r[27:16], 1'b0);
        end
      end
      begin
        repeat (LINK_DOWN_CYC) @(negedge clk_i);
        check_count("link_drop credits while down", pulses0, credit_pulses);
        check_count("link_drop reports while down", seq0, seq_num_q.size());
        link_up_i = 1'b1;
      end
    join
    wait_drain("link_drop");
    check_reports("link_drop");
    // store flags were wiped, so init starts over
    check_flag("link_drop fc1_done after link up", 1'b0, fc1_done_o);
  endtask

  task automatic unknown_type_discard();
    logic [31:0] r;
    int          err0;
    err0 = crc_err_cnt;
    r = next_random();
    // 8'h20 is a pm type, not handled on this path
    send_dllp({8'h20, r[23:0]}, 16'h0000, 1'b1);
    send_ack(1'b1, r[31:20], 1'b1);
    wait_drain("unknown_type");
    check_count("unknown_type crc_err pulses", err0, crc_err_cnt);
    check_reports("unknown_type");
    check_all_credits("unknown_type");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    rst_i      = 1'b1;
    link_up_i  = 1'b0;
    rx_word_i  = '0;
    rx_last_i  = 1'b0;
    rx_valid_i = 1'b0;
    for (int c = 0; c < pcie_dll_pkg::NUM_FC_CLASSES; c++) begin
      exp_hdr[c]  = '0;
      exp_data[c] = '0;
    end
    repeat (RESET_CYC) @(posedge clk_i);
    @(negedge clk_i);
    rst_i     = 1'b0;
    link_up_i = 1'b1;
    @(negedge clk_i);
    check_flag("reset fc1_done", 1'b0, fc1_done_o);
    check_flag("reset fc2_done", 1'b0, fc2_done_o);
    check_all_credits("reset");

    ack_nak_reports();
    corrupted_crc();
    fc_initialization();
    np_credit_update();
    link_drop_backpressure();
    unknown_type_discard();

    $display("checks %0d, errors %0d, credit errors %0d", checks, errors, credit_errors);
    if (errors == 0 && credit_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
common/pcie_dll_pkg.sv
hw/dllp_rx/dllp_rx_buffer.sv
hw/dllp_rx/dllp_crc16.sv
hw/dllp_rx/dllp_decoder.sv
hw/fc_credit_store.sv
hw/fc_init_tracker.sv
hw/dll_rx_top.sv
sim/tb_clk_gen.sv
sim/dll_rx_tb.sv

// File: Makefile
# Verilator build and run of the DLL receive testbench

VERILATOR ?= verilator
TOP       ?= dll_rx_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= Simulation finished: FAIL
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "$(TOP) failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "$(TOP) ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "$(TOP) passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
